/* bench/cluster_periph_sva.sv */
// ----------------------------------------------------------------------
// Cluster peripheral assertions
// Register bus response timing and the output state during reset.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "periph_cfg.svh"

module cluster_periph_sva (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        req_valid_i,
  input logic                        rsp_valid_i,
  input logic                        rsp_error_i,
  input logic [`PERIPH_NR_CORES-1:0] cl_clint_i,
  input logic                        prefetch_en_i
);

  // Every request gets its response pulse exactly one cycle later.
  a_rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i == $past(req_valid_i))
    else $error("rsp_valid_o does not follow req_valid_i by one cycle");

  // Outputs stay quiet while reset is held.
  a_reset_state: assert property (@(posedge clk_i)
    !rst_n_i |-> (!rsp_valid_i && cl_clint_i == '0 && !prefetch_en_i))
    else $error("outputs are not low during reset");

  a_error_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_error_i |-> rsp_valid_i)
    else $error("rsp_error_o is high without rsp_valid_o");

endmodule

bind cluster_periph_top cluster_periph_sva u_sva (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .req_valid_i   (req_valid_i),
  .rsp_valid_i   (rsp_valid_o),
  .rsp_error_i   (rsp_error_o),
  .cl_clint_i    (cl_clint_o),
  .prefetch_en_i (icache_prefetch_enable_o)
);

/* bench/cluster_periph_tb.sv */
// ----------------------------------------------------------------------
// Cluster peripheral testbench
// Directed register bus tests of the wake-up, prefetch and counters.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "periph_cfg.svh"

module cluster_periph_tb
  import perf_event_pkg::*;
();

  localparam int RSP_TIMEOUT = 8;
  localparam int EV_CYCLES = 64;
  localparam int N_READS = 10;

  logic                                         clk;
  logic                                         rst_n;
  logic                                         req_valid;
  logic                                         req_write;
  logic [7:0]                                   req_addr;
  logic [31:0]                                  req_wdata;
  logic                                         rsp_valid;
  logic [31:0]                                  rsp_rdata;
  logic                                         rsp_error;
  logic [`PERIPH_NR_CORES-1:0][CORE_EV_W-1:0]   core_events;
  logic [`PERIPH_NR_CORES-1:0][ICACHE_EV_W-1:0] icache_events;
  logic [TCDM_EV_W-1:0]                         tcdm_events;
  logic [`PERIPH_NR_CORES-1:0]                  cl_clint;
  logic                                         prefetch_en;
  logic [`PERIPH_NR_CORES-1:0]                  clint_model;

  cluster_periph_top DUT (
    .clk_i                    (clk),
    .rst_n_i                  (rst_n),
    .req_valid_i              (req_valid),
    .req_write_i              (req_write),
    .req_addr_i               (req_addr),
    .req_wdata_i              (req_wdata),
    .rsp_valid_o              (rsp_valid),
    .rsp_rdata_o              (rsp_rdata),
    .rsp_error_o              (rsp_error),
    .core_events_i            (core_events),
    .icache_events_i          (icache_events),
    .tcdm_events_i            (tcdm_events),
    .cl_clint_o               (cl_clint),
    .icache_prefetch_enable_o (prefetch_en)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [7:0] sel_addr(input int idx);
    return 8'(`PERIPH_OFS_SEL_BASE + 4 * idx);
  endfunction

  function automatic logic [7:0] cnt_addr(input int idx);
    return 8'(`PERIPH_OFS_CNT_BASE + 4 * idx);
  endfunction

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  // One request cycle, then wait for the response pulse.
  task automatic bus_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic exp_err,
                            output logic [31:0] rdata);
    int waited;
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_wdata = wdata;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    waited = 0;
    while (!rsp_valid && waited < RSP_TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    assert (rsp_valid) else begin
      $display("Error: no bus response for address 0x%02h within %0d cycles",
               addr, RSP_TIMEOUT);
      abort_run();
    end
    check_value("rsp_error_o", {31'b0, rsp_error}, {31'b0, exp_err});
    rdata = rsp_rdata;
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] wdata,
                           input logic exp_err);
    logic [31:0] rdata;
    bus_access(1'b1, addr, wdata, exp_err, rdata);
    check_value("rsp_rdata_o", rdata, 32'h0);
  endtask

  task automatic bus_read(input logic [7:0] addr, input logic exp_err,
                          output logic [31:0] rdata);
    bus_access(1'b0, addr, 32'h0, exp_err, rdata);
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    bus_read(addr, 1'b0, rdata);
    check_value($sformatf("rsp_rdata_o @0x%02h", addr), rdata, exp);
  endtask

  // Events low long enough to leave the capture and count pipeline.
  task automatic drain_events();
    core_events   = '0;
    icache_events = '0;
    tcdm_events   = '0;
    repeat (3) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic test_reset_state();
    // Cycle, RetiredInstr, TcdmAccessed and IcacheMiss, all on hart 0.
    logic [31:0] rst_sel [`PERIPH_NUM_CNT] = '{32'h0, 32'h1, 32'h4, 32'h6};
    for (int i = 0; i < `PERIPH_NUM_CNT; i++) begin
      read_check(cnt_addr(i), 32'h0);
      read_check(sel_addr(i), rst_sel[i]);
    end
    check_value("cl_clint_o", 32'(cl_clint), 32'h0);
    check_value("icache_prefetch_enable_o", {31'b0, prefetch_en}, 32'h0);
  endtask

  task automatic test_clint_prefetch();
    logic [31:0] bits;
    for (int n = 0; n < 12; n++) begin
      bits = $urandom();
      if (bits[31]) begin
        bus_write(`PERIPH_OFS_CLINT_SET, bits, 1'b0);
        clint_model = clint_model | bits[`PERIPH_NR_CORES-1:0];
      end else begin
        bus_write(`PERIPH_OFS_CLINT_CLR, bits, 1'b0);
        clint_model = clint_model & ~bits[`PERIPH_NR_CORES-1:0];
      end
      check_value("cl_clint_o", 32'(cl_clint), 32'(clint_model));
    end
    read_check(`PERIPH_OFS_CLINT_SET, 32'(clint_model));
    read_check(`PERIPH_OFS_CLINT_CLR, 32'(clint_model));
    bus_write(`PERIPH_OFS_PREFETCH, 32'h1, 1'b0);
    check_value("icache_prefetch_enable_o", {31'b0, prefetch_en}, 32'h1);
    read_check(`PERIPH_OFS_PREFETCH, 32'h1);
    bus_write(`PERIPH_OFS_PREFETCH, 32'h0, 1'b0);
    check_value("icache_prefetch_enable_o", {31'b0, prefetch_en}, 32'h0);
  endtask

  task automatic test_cycle_count();
    bus_write(`PERIPH_OFS_CNT_EN, 32'h1, 1'b0);
    // Each read sees the count from before its own edge.
    for (int k = 0; k < N_READS; k++) begin
      read_check(cnt_addr(0), 32'(k));
    end
    // The enabling edge does not count, the disabling edge does.
    bus_write(`PERIPH_OFS_CNT_EN, 32'h0, 1'b0);
    read_check(cnt_addr(0), 32'(N_READS + 1));
    bus_write(cnt_addr(0), 32'hDEAD_BEEF, 1'b0);
    read_check(cnt_addr(0), 32'h0);
  endtask

  task automatic test_hart_events();
    logic [31:0] pattern;
    int          expected;
    expected = 0;
    // RetiredLoad on hart 2.
    bus_write(sel_addr(1), 32'h0000_0202, 1'b0);
    read_check(sel_addr(1), 32'h0000_0202);
    bus_write(`PERIPH_OFS_CNT_EN, 32'h2, 1'b0);
    for (int n = 0; n < EV_CYCLES; n++) begin
      pattern       = $urandom();
      core_events   = pattern[0 +: `PERIPH_NR_CORES * CORE_EV_W];
      icache_events = pattern[16 +: `PERIPH_NR_CORES * ICACHE_EV_W];
      if (core_events[2][CORE_RETIRED_LOAD_BIT]) begin
        expected++;
      end
      @(posedge clk);
      #2;
    end
    drain_events();
    read_check(cnt_addr(1), 32'(expected));
  endtask

  task automatic test_tcdm_icache();
    logic [31:0] pattern;
    int          tcdm_exp;
    int          icache_exp;
    tcdm_exp   = 0;
    icache_exp = 0;
    // TcdmCongested on counter 2 and IcacheHit of hart 1 on counter 3.
    bus_write(sel_addr(2), 32'h0000_0005, 1'b0);
    bus_write(sel_addr(3), 32'h0000_0107, 1'b0);
    bus_write(`PERIPH_OFS_CNT_EN, 32'hC, 1'b0);
    for (int n = 0; n < EV_CYCLES; n++) begin
      pattern       = $urandom();
      tcdm_events   = pattern[0 +: TCDM_EV_W];
      icache_events = pattern[8 +: `PERIPH_NR_CORES * ICACHE_EV_W];
      core_events   = pattern[20 +: `PERIPH_NR_CORES * CORE_EV_W];
      if (tcdm_events[TCDM_CONGESTED_BIT]) begin
        tcdm_exp++;
      end
      if (icache_events[1][ICACHE_HIT_BIT]) begin
        icache_exp++;
      end
      @(posedge clk);
      #2;
    end
    drain_events();
    read_check(cnt_addr(2), 32'(tcdm_exp));
    read_check(cnt_addr(3), 32'(icache_exp));
  endtask

  task automatic test_unmapped();
    logic [31:0] rdata;
    // Idle wake-up state first, so a stray set shows up.
    bus_write(`PERIPH_OFS_CLINT_CLR, 32'h0000_000F, 1'b0);
    clint_model = '0;
    // Misaligned addresses next to the enable and CLINT set registers.
    bus_write(8'h02, 32'h0000_000F, 1'b1);
    bus_write(8'h05, 32'h0000_000F, 1'b1);
    bus_write(8'h50, 32'hFFFF_FFFF, 1'b1);
    bus_read(8'h7C, 1'b1, rdata);
    read_check(`PERIPH_OFS_CNT_EN, 32'hC);
    read_check(`PERIPH_OFS_CLINT_SET, 32'(clint_model));
    read_check(`PERIPH_OFS_PREFETCH, 32'h0);
    read_check(sel_addr(0), 32'h0);
    check_value("cl_clint_o", 32'(cl_clint), 32'(clint_model));
  endtask

  initial begin
    void'($urandom(32'h4529));
    rst_n         = 1'b1;
    req_valid     = 1'b0;
    req_write     = 1'b0;
    req_addr      = '0;
    req_wdata     = '0;
    core_events   = '0;
    icache_events = '0;
    tcdm_events   = '0;
    clint_model   = '0;
    // Falling edge before the first clock so the asynchronous reset acts at once.
    #1;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    test_reset_state();
    test_clint_prefetch();
    test_cycle_count();
    test_hart_events();
    test_tcdm_icache();
    test_unmapped();
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
logic/perf_event_pkg.sv
logic/periph_reg_pkg.sv
logic/periph_event_capture.sv
logic/perf_counter_unit.sv
logic/periph_reg_file.sv
logic/cluster_periph_top.sv
bench/cluster_periph_sva.sv
bench/cluster_periph_tb.sv

/* include/periph_cfg.svh */
// ----------------------------------------------------------------------
// Cluster peripheral configuration
// Sizes of the core array and counters, and the register map offsets.
// ----------------------------------------------------------------------
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Cluster and counter sizing.
`define PERIPH_NR_CORES 4
`define PERIPH_NUM_CNT 4
`define PERIPH_CNT_W 32
`define PERIPH_HART_W 2

// Byte offsets of the single registers.
`define PERIPH_OFS_CNT_EN 8'h00
`define PERIPH_OFS_CLINT_SET 8'h04
`define PERIPH_OFS_CLINT_CLR 8'h08
`define PERIPH_OFS_PREFETCH 8'h0C

// Per-counter register arrays, one word per counter.
`define PERIPH_OFS_SEL_BASE 8'h10
`define PERIPH_OFS_CNT_BASE 8'h30

`endif

/* logic/cluster_periph_top.sv */
// ----------------------------------------------------------------------
// Cluster peripheral top level
// Event capture stage, the performance counters and the register file.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "periph_cfg.svh"

module cluster_periph_top
  import perf_event_pkg::*;
(
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         req_valid_i,
  input  logic                                         req_write_i,
  input  logic [7:0]                                   req_addr_i,
  input  logic [31:0]                                  req_wdata_i,
  output logic                                         rsp_valid_o,
  output logic [31:0]                                  rsp_rdata_o,
  output logic                                         rsp_error_o,
  input  logic [`PERIPH_NR_CORES-1:0][CORE_EV_W-1:0]   core_events_i,
  input  logic [`PERIPH_NR_CORES-1:0][ICACHE_EV_W-1:0] icache_events_i,
  input  logic [TCDM_EV_W-1:0]                         tcdm_events_i,
  output logic [`PERIPH_NR_CORES-1:0]                  cl_clint_o,
  output logic                                         icache_prefetch_enable_o
);

  logic [`PERIPH_NR_CORES-1:0][CORE_EV_W-1:0]   core_events_q;
  logic [`PERIPH_NR_CORES-1:0][ICACHE_EV_W-1:0] icache_events_q;
  logic [TCDM_EV_W-1:0]                         tcdm_events_q;
  logic [`PERIPH_NUM_CNT-1:0]                   cnt_en;
  logic [`PERIPH_NUM_CNT-1:0]                   cnt_clr;
  logic [`PERIPH_NUM_CNT-1:0]                   sel_wr;
  logic [31:0]                                  sel_wdata;
  logic [`PERIPH_NUM_CNT-1:0][`PERIPH_CNT_W-1:0] cnt_val;
  logic [`PERIPH_NUM_CNT-1:0][31:0]             sel_val;

  periph_event_capture u_capture (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .core_events_i   (core_events_i),
    .icache_events_i (icache_events_i),
    .tcdm_events_i   (tcdm_events_i),
    .core_events_o   (core_events_q),
    .icache_events_o (icache_events_q),
    .tcdm_events_o   (tcdm_events_q)
  );

  // Each counter starts on its own reset metric.
  for (genvar i = 0; i < `PERIPH_NUM_CNT; i++) begin : gen_cnt
    perf_counter_unit #(
      .RST_METRIC (perf_metric_rst[i])
    ) u_cnt (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .cnt_en_i        (cnt_en[i]),
      .cnt_clr_i       (cnt_clr[i]),
      .sel_wr_i        (sel_wr[i]),
      .sel_wdata_i     (sel_wdata),
      .core_events_i   (core_events_q),
      .icache_events_i (icache_events_q),
      .tcdm_events_i   (tcdm_events_q),
      .cnt_val_o       (cnt_val[i]),
      .sel_val_o       (sel_val[i])
    );
  end

  periph_reg_file u_regs (
    .clk_i                    (clk_i),
    .rst_n_i                  (rst_n_i),
    .req_valid_i              (req_valid_i),
    .req_write_i              (req_write_i),
    .req_addr_i               (req_addr_i),
    .req_wdata_i              (req_wdata_i),
    .rsp_valid_o              (rsp_valid_o),
    .rsp_rdata_o              (rsp_rdata_o),
    .rsp_error_o              (rsp_error_o),
    .cnt_val_i                (cnt_val),
    .sel_val_i                (sel_val),
    .cnt_en_o                 (cnt_en),
    .cnt_clr_o                (cnt_clr),
    .sel_wr_o                 (sel_wr),
    .sel_wdata_o              (sel_wdata),
    .cl_clint_o               (cl_clint_o),
    .icache_prefetch_enable_o (icache_prefetch_enable_o)
  );

endmodule

/* logic/perf_counter_unit.sv */
// ----------------------------------------------------------------------
// Performance counter unit
// One counter with its own metric and hart select, counting the chosen
// event while enabled, cleared by a write to its value register.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "periph_cfg.svh"

module perf_counter_unit
  import perf_event_pkg::*;
  import periph_reg_pkg::*;
#(
  parameter perf_metric_e RST_METRIC = Cycle
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         cnt_en_i,
  input  logic                                         cnt_clr_i,
  input  logic                                         sel_wr_i,
  input  logic [31:0]                                  sel_wdata_i,
  input  logic [`PERIPH_NR_CORES-1:0][CORE_EV_W-1:0]   core_events_i,
  input  logic [`PERIPH_NR_CORES-1:0][ICACHE_EV_W-1:0] icache_events_i,
  input  logic [TCDM_EV_W-1:0]                         tcdm_events_i,
  output logic [`PERIPH_CNT_W-1:0]                     cnt_val_o,
  output logic [31:0]                                  sel_val_o
);

  perf_metric_e              metric_q;
  logic [`PERIPH_HART_W-1:0] hart_q;
  logic [`PERIPH_CNT_W-1:0]  cnt_q;
  logic                      inc;

  // Event bit for the current metric, taken from the selected hart.
  always_comb begin
    inc = 1'b0;
    case (metric_q)
      Cycle:         inc = 1'b1;
      RetiredInstr:  inc = core_events_i[hart_q][CORE_RETIRED_INSTR_BIT];
      RetiredLoad:   inc = core_events_i[hart_q][CORE_RETIRED_LOAD_BIT];
      IssueFpu:      inc = core_events_i[hart_q][CORE_ISSUE_FPU_BIT];
      TcdmAccessed:  inc = tcdm_events_i[TCDM_ACCESSED_BIT];
      TcdmCongested: inc = tcdm_events_i[TCDM_CONGESTED_BIT];
      IcacheMiss:    inc = icache_events_i[hart_q][ICACHE_MISS_BIT];
      IcacheHit:     inc = icache_events_i[hart_q][ICACHE_HIT_BIT];
      default:       inc = 1'b0;
    endcase
  end

  // Metric and hart selection.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      metric_q <= RST_METRIC;
      hart_q   <= '0;
    end else if (sel_wr_i) begin
      metric_q <= perf_metric_e'(sel_wdata_i[SEL_METRIC_LSB +: $bits(perf_metric_e)]);
      hart_q   <= sel_wdata_i[SEL_HART_LSB +: `PERIPH_HART_W];
    end
  end

  // Count register, a clear beats the increment.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_clr_i) begin
      cnt_q <= '0;
    end else if (cnt_en_i) begin
      cnt_q <= cnt_q + {{(`PERIPH_CNT_W-1){1'b0}}, inc};
    end
  end

  assign cnt_val_o = cnt_q;

  always_comb begin
    sel_val_o = '0;
    sel_val_o[SEL_METRIC_LSB +: $bits(perf_metric_e)] = metric_q;
    sel_val_o[SEL_HART_LSB +: `PERIPH_HART_W] = hart_q;
  end

endmodule

/* logic/perf_event_pkg.sv */
// ----------------------------------------------------------------------
// Performance event package
// Metric codes, event vector widths and event bit positions.
// ----------------------------------------------------------------------
`include "periph_cfg.svh"

package perf_event_pkg;

  // Metric code held in each counter select word.
  // Codes 8 to 15 are legal but count nothing.
  typedef enum logic [3:0] {
    Cycle         = 4'd0,
    RetiredInstr  = 4'd1,
    RetiredLoad   = 4'd2,
    IssueFpu      = 4'd3,
    TcdmAccessed  = 4'd4,
    TcdmCongested = 4'd5,
    IcacheMiss    = 4'd6,
    IcacheHit     = 4'd7
  } perf_metric_e;

  // Per-core events from the integer pipeline.
  localparam int unsigned CORE_EV_W = 3;
  localparam int unsigned CORE_RETIRED_INSTR_BIT = 0;
  localparam int unsigned CORE_RETIRED_LOAD_BIT = 1;
  localparam int unsigned CORE_ISSUE_FPU_BIT = 2;

  // Per-core L0 instruction cache events.
  localparam int unsigned ICACHE_EV_W = 2;
  localparam int unsigned ICACHE_MISS_BIT = 0;
  localparam int unsigned ICACHE_HIT_BIT = 1;

  // Shared scratchpad (TCDM) events.
  localparam int unsigned TCDM_EV_W = 2;
  localparam int unsigned TCDM_ACCESSED_BIT = 0;
  localparam int unsigned TCDM_CONGESTED_BIT = 1;

  // Metrics tracked right after reset, one per counter.
  localparam perf_metric_e perf_metric_rst [`PERIPH_NUM_CNT] = '{
    Cycle,
    RetiredInstr,
    TcdmAccessed,
    IcacheMiss
  };

endpackage

/* logic/periph_event_capture.sv */
// ----------------------------------------------------------------------
// Event capture stage
// Registers all core, cache and scratchpad events once so the counter
// adders see clean flop outputs.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_event_capture
  import perf_event_pkg::*;
(
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic [`PERIPH_NR_CORES-1:0][CORE_EV_W-1:0]   core_events_i,
  input  logic [`PERIPH_NR_CORES-1:0][ICACHE_EV_W-1:0] icache_events_i,
  input  logic [TCDM_EV_W-1:0]                         tcdm_events_i,
  output logic [`PERIPH_NR_CORES-1:0][CORE_EV_W-1:0]   core_events_o,
  output logic [`PERIPH_NR_CORES-1:0][ICACHE_EV_W-1:0] icache_events_o,
  output logic [TCDM_EV_W-1:0]                         tcdm_events_o
);

  logic [`PERIPH_NR_CORES-1:0][CORE_EV_W-1:0]   core_events_q;
  logic [`PERIPH_NR_CORES-1:0][ICACHE_EV_W-1:0] icache_events_q;
  logic [TCDM_EV_W-1:0]                         tcdm_events_q;

  // One pipeline stage for every event bit.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      core_events_q   <= '0;
      icache_events_q <= '0;
      tcdm_events_q   <= '0;
    end else begin
      core_events_q   <= core_events_i;
      icache_events_q <= icache_events_i;
      tcdm_events_q   <= tcdm_events_i;
    end
  end

  assign core_events_o   = core_events_q;
  assign icache_events_o = icache_events_q;
  assign tcdm_events_o   = tcdm_events_q;

endmodule

/* logic/periph_reg_file.sv */
// ----------------------------------------------------------------------
// Peripheral register file
// Decodes register bus accesses, holds enable, wake-up and prefetch
// state, strobes the counters and returns read data one cycle later.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_reg_file
  import periph_reg_pkg::*;
(
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          req_valid_i,
  input  logic                                          req_write_i,
  input  logic [7:0]                                    req_addr_i,
  input  logic [31:0]                                   req_wdata_i,
  output logic                                          rsp_valid_o,
  output logic [31:0]                                   rsp_rdata_o,
  output logic                                          rsp_error_o,
  input  logic [`PERIPH_NUM_CNT-1:0][`PERIPH_CNT_W-1:0] cnt_val_i,
  input  logic [`PERIPH_NUM_CNT-1:0][31:0]              sel_val_i,
  output logic [`PERIPH_NUM_CNT-1:0]                    cnt_en_o,
  output logic [`PERIPH_NUM_CNT-1:0]                    cnt_clr_o,
  output logic [`PERIPH_NUM_CNT-1:0]                    sel_wr_o,
  output logic [31:0]                                   sel_wdata_o,
  output logic [`PERIPH_NR_CORES-1:0]                   cl_clint_o,
  output logic                                          icache_prefetch_enable_o
);

  localparam int unsigned IDX_W = $clog2(`PERIPH_NUM_CNT);
  localparam logic [7:0] ARR_SPAN = 8'(4 * `PERIPH_NUM_CNT);

  periph_reg_e               reg_kind;
  logic [IDX_W-1:0]          cnt_idx;
  logic [7:0]                sel_ofs;
  logic [7:0]                val_ofs;
  logic                      wr;
  logic [31:0]               rdata_d;
  logic [`PERIPH_NUM_CNT-1:0] cnt_en_q;
  logic [`PERIPH_NR_CORES-1:0] clint_q;
  logic                      prefetch_q;
  logic                      rsp_valid_q;
  logic                      rsp_error_q;
  logic [31:0]               rsp_rdata_q;

  assign wr = req_valid_i & req_write_i;
  assign sel_ofs = req_addr_i - `PERIPH_OFS_SEL_BASE;
  assign val_ofs = req_addr_i - `PERIPH_OFS_CNT_BASE;

  // Address decode, misaligned accesses fall through to RegInvalid.
  always_comb begin
    reg_kind = RegInvalid;
    cnt_idx  = '0;
    if (req_addr_i[1:0] == 2'b00) begin
      if (req_addr_i == `PERIPH_OFS_CNT_EN) begin
        reg_kind = RegCntEn;
      end else if (req_addr_i == `PERIPH_OFS_CLINT_SET) begin
        reg_kind = RegClintSet;
      end else if (req_addr_i == `PERIPH_OFS_CLINT_CLR) begin
        reg_kind = RegClintClr;
      end else if (req_addr_i == `PERIPH_OFS_PREFETCH) begin
        reg_kind = RegPrefetch;
      end else if (req_addr_i >= `PERIPH_OFS_SEL_BASE && sel_ofs < ARR_SPAN) begin
        reg_kind = RegCntSel;
        cnt_idx  = sel_ofs[IDX_W+1:2];
      end else if (req_addr_i >= `PERIPH_OFS_CNT_BASE && val_ofs < ARR_SPAN) begin
        reg_kind = RegCntVal;
        cnt_idx  = val_ofs[IDX_W+1:2];
      end
    end
  end

  // Control registers.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_en_q   <= '0;
      clint_q    <= '0;
      prefetch_q <= 1'b0;
    end else if (wr) begin
      case (reg_kind)
        RegCntEn:    cnt_en_q <= req_wdata_i[`PERIPH_NUM_CNT-1:0];
        RegClintSet: clint_q <= clint_q | req_wdata_i[`PERIPH_NR_CORES-1:0];
        RegClintClr: clint_q <= clint_q & ~req_wdata_i[`PERIPH_NR_CORES-1:0];
        RegPrefetch: prefetch_q <= req_wdata_i[0];
        default: ;
      endcase
    end
  end

  // One-cycle strobes to the addressed counter.
  always_comb begin
    sel_wr_o  = '0;
    cnt_clr_o = '0;
    if (wr && reg_kind == RegCntSel) begin
      sel_wr_o[cnt_idx] = 1'b1;
    end
    if (wr && reg_kind == RegCntVal) begin
      cnt_clr_o[cnt_idx] = 1'b1;
    end
  end

  assign sel_wdata_o = req_wdata_i;

  // Read mux, writes return zero.
  always_comb begin
    rdata_d = '0;
    if (!req_write_i) begin
      case (reg_kind)
        RegCntEn:    rdata_d[`PERIPH_NUM_CNT-1:0] = cnt_en_q;
        RegClintSet,
        RegClintClr: rdata_d[`PERIPH_NR_CORES-1:0] = clint_q;
        RegPrefetch: rdata_d[0] = prefetch_q;
        RegCntSel:   rdata_d = sel_val_i[cnt_idx];
        RegCntVal:   rdata_d[`PERIPH_CNT_W-1:0] = cnt_val_i[cnt_idx];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_error_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
      rsp_error_q <= req_valid_i && (reg_kind == RegInvalid);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_rdata_q <= rdata_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_error_o = rsp_error_q;
  assign rsp_rdata_o = rsp_rdata_q;

  assign cnt_en_o = cnt_en_q;
  assign cl_clint_o = clint_q;
  assign icache_prefetch_enable_o = prefetch_q;

endmodule

/* logic/periph_reg_pkg.sv */
// ----------------------------------------------------------------------
// Peripheral register package
// Decoded register kinds and the counter select word layout.
// ----------------------------------------------------------------------
package periph_reg_pkg;

  // Register kind produced by the address decoder.
  typedef enum logic [2:0] {
    RegCntEn    = 3'd0,
    RegClintSet = 3'd1,
    RegClintClr = 3'd2,
    RegPrefetch = 3'd3,
    RegCntSel   = 3'd4,
    RegCntVal   = 3'd5,
    RegInvalid  = 3'd7
  } periph_reg_e;

  // Counter select word.
  // Metric in bits 3:0, hart in bits 9:8, all others read as zero.
  localparam int unsigned SEL_METRIC_LSB = 0;
  localparam int unsigned SEL_HART_LSB = 8;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Builds the cluster peripheral testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero on any failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module cluster_periph_tb \
  -o cluster_periph_sim \
  && ./obj_dir/cluster_periph_sim \
  || { echo "simulation did not complete successfully"; exit 1; }
